//--- dsi_tx_pkg.sv
package dsi_tx_pkg;

  typedef logic [23:0] pkt_header_t;  // {word count, data type}
  typedef logic [15:0] word_count_t;
  typedef logic [15:0] crc_t;
  typedef logic [7:0]  ecc_t;
  typedef logic [3:0]  lane_mask_t;   // one bit per phy lane

  // on the sequencer side lp marks a header that still needs its ecc
  typedef struct packed {
    logic        lp;
    logic        half;  // only data[15:0] valid
    logic [31:0] data;  // byte 0 goes out first
  } stage_word_t;

  localparam logic [7:0] dt_vss     = 8'h01;
  localparam logic [7:0] dt_hss     = 8'h21;
  localparam logic [7:0] dt_pixel24 = 8'h3E;

  typedef enum logic [3:0] {
    idle,
    vss,
    blank_vss,
    hss_vsa,
    blank_vsa,
    hss_vbp,
    blank_vbp,
    hss_act,
    blank_hbp,
    pix_header,
    pix_data,
    pix_crc,
    blank_hfp,
    hss_vfp,
    blank_vfp
  } seq_state_e;

endpackage

//--- dsi_ecc.sv
`timescale 1ns/100ps

module dsi_ecc (
  input  dsi_tx_pkg::pkt_header_t header,
  output dsi_tx_pkg::ecc_t        ecc
);

  // header bits covered by each hamming parity bit
  localparam logic [23:0] p0_mask = 24'hF12CB7;
  localparam logic [23:0] p1_mask = 24'hF2555B;
  localparam logic [23:0] p2_mask = 24'h749A6D;
  localparam logic [23:0] p3_mask = 24'hB8E38E;
  localparam logic [23:0] p4_mask = 24'hDF03F0;
  localparam logic [23:0] p5_mask = 24'hEFFC00;

  assign ecc = {
    2'b00,  // top bits unused
    ^(header & p5_mask),
    ^(header & p4_mask),
    ^(header & p3_mask),
    ^(header & p2_mask),
    ^(header & p1_mask),
    ^(header & p0_mask)
  };

endmodule

//--- dsi_crc16.sv
`timescale 1ns/100ps

module dsi_crc16 (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear,
  input  logic             write,
  input  logic [31:0]      data,
  output dsi_tx_pkg::crc_t crc
);

  localparam logic [15:0] poly_rev = 16'h8408;  // x^16+x^12+x^5+1 reflected

  function automatic dsi_tx_pkg::crc_t fold32(input dsi_tx_pkg::crc_t crc_in,
                                              input logic [31:0] din);
    dsi_tx_pkg::crc_t c;
    c = crc_in;
    for (int i = 0; i < 32; i++)
    begin
      if (c[0] ^ din[i])  // lsb first, byte 0 first
        c = (c >> 1) ^ poly_rev;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      crc <= 16'hFFFF;
    else if (clear)
      crc <= 16'hFFFF;
    else if (write)
      crc <= fold32(crc, data);
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(clear && write))
    else $error("crc clear and write together");

endmodule

//--- frame_sequencer.sv
`timescale 1ns/100ps

module frame_sequencer #(
  parameter int line_bytes = 8,
  parameter int blank_time = 6,
  parameter int vsa_lines  = 1,
  parameter int vbp_lines  = 1,
  parameter int act_lines  = 2,
  parameter int vfp_lines  = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable,
  input  logic [31:0]             fifo_data,
  input  logic                    fifo_not_empty,
  input  logic                    fifo_line_ready,
  input  logic                    seq_grant,
  output logic                    fifo_read_ack,
  output logic                    seq_req,
  output dsi_tx_pkg::stage_word_t seq_word,
  output logic                    seq_busy,
  output logic                    pix_underflow
);

  dsi_tx_pkg::seq_state_e  state;
  dsi_tx_pkg::seq_state_e  state_nxt;
  dsi_tx_pkg::word_count_t blank_cnt;
  dsi_tx_pkg::word_count_t line_cnt;
  dsi_tx_pkg::word_count_t line_load;
  dsi_tx_pkg::word_count_t word_cnt;
  dsi_tx_pkg::crc_t        crc;
  dsi_tx_pkg::pkt_header_t header;
  logic                    blank_done;
  logic                    last_line;
  logic                    line_end;

  assign blank_done = (blank_cnt == '0);
  assign last_line  = (line_cnt == 16'd1);
  assign line_end   = blank_done && (state == dsi_tx_pkg::blank_vsa ||
                                     state == dsi_tx_pkg::blank_vbp ||
                                     state == dsi_tx_pkg::blank_hfp ||
                                     state == dsi_tx_pkg::blank_vfp);

  always_comb
  begin
    state_nxt = state;
    case (state)
      dsi_tx_pkg::idle:       if (enable && fifo_line_ready) state_nxt = dsi_tx_pkg::vss;
      dsi_tx_pkg::vss:        if (seq_grant) state_nxt = dsi_tx_pkg::blank_vss;
      dsi_tx_pkg::blank_vss:  if (blank_done) state_nxt = dsi_tx_pkg::hss_vsa;
      dsi_tx_pkg::hss_vsa:    if (seq_grant) state_nxt = dsi_tx_pkg::blank_vsa;
      dsi_tx_pkg::blank_vsa:
        if (blank_done) state_nxt = last_line ? dsi_tx_pkg::hss_vbp : dsi_tx_pkg::hss_vsa;
      dsi_tx_pkg::hss_vbp:    if (seq_grant) state_nxt = dsi_tx_pkg::blank_vbp;
      dsi_tx_pkg::blank_vbp:
        if (blank_done) state_nxt = last_line ? dsi_tx_pkg::hss_act : dsi_tx_pkg::hss_vbp;
      dsi_tx_pkg::hss_act:    if (seq_grant) state_nxt = dsi_tx_pkg::blank_hbp;
      dsi_tx_pkg::blank_hbp:  if (blank_done) state_nxt = dsi_tx_pkg::pix_header;
      dsi_tx_pkg::pix_header: if (seq_grant) state_nxt = dsi_tx_pkg::pix_data;
      dsi_tx_pkg::pix_data:   if (seq_grant && word_cnt == 16'd1) state_nxt = dsi_tx_pkg::pix_crc;
      dsi_tx_pkg::pix_crc:    if (seq_grant) state_nxt = dsi_tx_pkg::blank_hfp;
      dsi_tx_pkg::blank_hfp:
        if (blank_done) state_nxt = last_line ? dsi_tx_pkg::hss_vfp : dsi_tx_pkg::hss_act;
      dsi_tx_pkg::hss_vfp:    if (seq_grant) state_nxt = dsi_tx_pkg::blank_vfp;
      dsi_tx_pkg::blank_vfp:
        if (blank_done) state_nxt = last_line ? dsi_tx_pkg::idle : dsi_tx_pkg::hss_vfp;
      default:                state_nxt = dsi_tx_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= dsi_tx_pkg::idle;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      blank_cnt <= '0;
    else if (state_nxt != state)
      blank_cnt <= dsi_tx_pkg::word_count_t'(blank_time - 1);  // reload on every change
    else if (blank_cnt != '0)
      blank_cnt <= blank_cnt - 16'd1;
  end

  always_comb
  begin
    case (state)
      dsi_tx_pkg::blank_vsa: line_load = dsi_tx_pkg::word_count_t'(vbp_lines);
      dsi_tx_pkg::blank_vbp: line_load = dsi_tx_pkg::word_count_t'(act_lines);
      dsi_tx_pkg::blank_hfp: line_load = dsi_tx_pkg::word_count_t'(vfp_lines);
      default:               line_load = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      line_cnt <= '0;
    else if (state == dsi_tx_pkg::idle && state_nxt == dsi_tx_pkg::vss)
      line_cnt <= dsi_tx_pkg::word_count_t'(vsa_lines);
    else if (line_end)
      line_cnt <= last_line ? line_load : line_cnt - 16'd1;  // next region count
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      word_cnt <= '0;
    else if (state == dsi_tx_pkg::pix_header)
      word_cnt <= dsi_tx_pkg::word_count_t'(line_bytes / 4);
    else if (fifo_read_ack)
      word_cnt <= word_cnt - 16'd1;
  end

  dsi_crc16 i_dsi_crc16 (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (state == dsi_tx_pkg::pix_header),
    .write (fifo_read_ack),
    .data  (fifo_data),
    .crc   (crc)
  );

  always_comb
  begin
    case (state)
      dsi_tx_pkg::vss:        header = {16'h0000, dsi_tx_pkg::dt_vss};
      dsi_tx_pkg::pix_header: header = {dsi_tx_pkg::word_count_t'(line_bytes), dsi_tx_pkg::dt_pixel24};
      default:                header = {16'h0000, dsi_tx_pkg::dt_hss};
    endcase
  end

  always_comb
  begin
    case (state)
      dsi_tx_pkg::vss, dsi_tx_pkg::hss_vsa, dsi_tx_pkg::hss_vbp,
      dsi_tx_pkg::hss_act, dsi_tx_pkg::hss_vfp, dsi_tx_pkg::pix_crc: seq_req = 1'b1;
      dsi_tx_pkg::pix_header: seq_req = fifo_line_ready;
      dsi_tx_pkg::pix_data:   seq_req = fifo_not_empty;  // only with pixels present
      default:                seq_req = 1'b0;
    endcase
  end

  always_comb
  begin
    case (state)
      dsi_tx_pkg::pix_data: seq_word = '{lp: 1'b0, half: 1'b0, data: fifo_data};
      dsi_tx_pkg::pix_crc:  seq_word = '{lp: 1'b0, half: 1'b1, data: {16'h0000, crc}};
      default:              seq_word = '{lp: 1'b1, half: 1'b0, data: {8'h00, header}};
    endcase
  end

  assign fifo_read_ack = seq_grant && (state == dsi_tx_pkg::pix_data);
  assign seq_busy      = (state != dsi_tx_pkg::idle);
  assign pix_underflow = (state == dsi_tx_pkg::pix_header) && !fifo_line_ready;

  assert property (@(posedge clk) disable iff (!rst_n) fifo_read_ack |-> fifo_not_empty)
    else $error("pixel read ack with pixel fifo empty");

endmodule

//--- packet_arbiter.sv
`timescale 1ns/100ps

module packet_arbiter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    send_cmd,
  input  dsi_tx_pkg::pkt_header_t cmd_packet,
  input  logic                    seq_req,
  input  dsi_tx_pkg::stage_word_t seq_word,
  input  logic                    seq_busy,
  input  logic                    full,
  output logic                    seq_grant,
  output logic                    wr,
  output dsi_tx_pkg::stage_word_t wr_word
);

  logic                    send_cmd_q;
  logic                    cmd_pending;
  logic                    cmd_grant;
  dsi_tx_pkg::pkt_header_t hdr;
  dsi_tx_pkg::ecc_t        ecc;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      send_cmd_q  <= 1'b0;
      cmd_pending <= 1'b0;
    end
    else
    begin
      send_cmd_q  <= send_cmd;
      cmd_pending <= (cmd_pending && !cmd_grant) || (send_cmd && !send_cmd_q);  // rising edge
    end
  end

  assign seq_grant = seq_req && !full;
  assign cmd_grant = cmd_pending && !seq_busy && !seq_req && !full;  // between frames only
  assign wr        = seq_grant || cmd_grant;

  assign hdr = cmd_grant ? cmd_packet : seq_word.data[23:0];

  dsi_ecc i_dsi_ecc (
    .header (hdr),
    .ecc    (ecc)
  );

  always_comb
  begin
    if (cmd_grant)
      wr_word = '{lp: 1'b1, half: 1'b0, data: {ecc, cmd_packet}};
    else if (seq_word.lp)
      wr_word = '{lp: 1'b0, half: 1'b0, data: {ecc, hdr}};  // sequencer header
    else
      wr_word = seq_word;
  end

  assert property (@(posedge clk) disable iff (!rst_n) seq_req |-> seq_busy)
    else $error("sequencer request while idle");

endmodule

//--- stage_fifo.sv
`timescale 1ns/100ps

module stage_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr,
  input  dsi_tx_pkg::stage_word_t wr_word,
  input  logic                    rd,
  output dsi_tx_pkg::stage_word_t rd_word,
  output logic                    empty,
  output logic                    full
);

  localparam int depth = 4;

  dsi_tx_pkg::stage_word_t      mem [depth];
  logic [$clog2(depth)-1:0]     wr_ptr;
  logic [$clog2(depth)-1:0]     rd_ptr;
  logic [$clog2(depth):0]       count;

  always_ff @(posedge clk)
  begin
    if (wr)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{$clog2(depth){1'b0}}, wr} - {{$clog2(depth){1'b0}}, rd};
    end
  end

  assign rd_word = mem[rd_ptr];  // show-ahead
  assign empty   = (count == '0);
  assign full    = (count == ($clog2(depth)+1)'(depth));

  assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
    else $error("staging fifo overflow");
  assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
    else $error("staging fifo underflow");

endmodule

//--- lane_repacker.sv
`timescale 1ns/100ps

module lane_repacker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dsi_tx_pkg::stage_word_t rd_word,
  input  logic                    empty,
  input  logic [2:0]              lanes,
  input  dsi_tx_pkg::lane_mask_t  phy_full,
  output logic                    rd,
  output logic [32:0]             phy_data,
  output dsi_tx_pkg::lane_mask_t  phy_write
);

  logic [63:0] shift_q;
  logic [3:0]  byte_cnt;
  logic        lp_mode;
  logic [3:0]  width;
  logic [3:0]  send_n;
  logic [3:0]  sent_n;
  logic [3:0]  remain;
  logic [3:0]  in_n;
  logic [31:0] in_data;
  logic        flush;
  logic        xfer;
  logic [7:0]  strobe_wide;

  assign width   = lp_mode ? 4'd1 : {1'b0, lanes};  // lp is single lane
  assign flush   = empty || (rd_word.lp != lp_mode);  // drain before a mode change
  assign xfer    = !(|phy_full) && (byte_cnt >= width || (byte_cnt != 4'd0 && flush));
  assign send_n  = (byte_cnt >= width) ? width : byte_cnt;
  assign sent_n  = xfer ? send_n : 4'd0;
  assign remain  = byte_cnt - sent_n;
  assign rd      = !empty && remain <= 4'd4 && (rd_word.lp == lp_mode || remain == 4'd0);
  assign in_n    = rd_word.half ? 4'd2 : 4'd4;
  assign in_data = rd_word.half ? {16'h0000, rd_word.data[15:0]} : rd_word.data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q  <= '0;
      byte_cnt <= '0;
      lp_mode  <= 1'b0;
    end
    else
    begin
      shift_q  <= (shift_q >> {sent_n, 3'b000}) |
                  (rd ? ({32'h0, in_data} << {remain, 3'b000}) : 64'h0);  // append above rest
      byte_cnt <= remain + (rd ? in_n : 4'd0);
      if (rd)
        lp_mode <= rd_word.lp;
    end
  end

  assign phy_data    = {lp_mode, shift_q[31:0]};
  assign strobe_wide = {4'b0000, {4{xfer}}} << send_n;
  assign phy_write   = strobe_wide[7:4];  // contiguous from lane 0

  assert property (@(posedge clk) disable iff (!rst_n) byte_cnt <= 4'd8)
    else $error("repacker byte count above 8");

endmodule

//--- dsi_tx_assembler.sv
`timescale 1ns/100ps

module dsi_tx_assembler #(
  parameter int line_bytes = 8,
  parameter int blank_time = 6,
  parameter int vsa_lines  = 1,
  parameter int vbp_lines  = 1,
  parameter int act_lines  = 2,
  parameter int vfp_lines  = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [31:0]             fifo_data,
  input  logic                    fifo_not_empty,
  input  logic                    fifo_line_ready,
  output logic                    fifo_read_ack,
  input  logic                    enable,
  input  logic                    send_cmd,
  input  dsi_tx_pkg::pkt_header_t cmd_packet,
  input  logic [2:0]              lanes,
  output logic [32:0]             phy_data,
  output dsi_tx_pkg::lane_mask_t  phy_write,
  input  dsi_tx_pkg::lane_mask_t  phy_full,
  output logic                    pix_underflow
);

  logic                    seq_req;
  logic                    seq_grant;
  logic                    seq_busy;
  dsi_tx_pkg::stage_word_t seq_word;
  logic                    wr;
  logic                    rd;
  logic                    empty;
  logic                    full;
  dsi_tx_pkg::stage_word_t wr_word;
  dsi_tx_pkg::stage_word_t rd_word;

  frame_sequencer #(
    .line_bytes (line_bytes),
    .blank_time (blank_time),
    .vsa_lines  (vsa_lines),
    .vbp_lines  (vbp_lines),
    .act_lines  (act_lines),
    .vfp_lines  (vfp_lines)
  ) i_frame_sequencer (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .fifo_data       (fifo_data),
    .fifo_not_empty  (fifo_not_empty),
    .fifo_line_ready (fifo_line_ready),
    .seq_grant       (seq_grant),
    .fifo_read_ack   (fifo_read_ack),
    .seq_req         (seq_req),
    .seq_word        (seq_word),
    .seq_busy        (seq_busy),
    .pix_underflow   (pix_underflow)
  );

  packet_arbiter i_packet_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .send_cmd   (send_cmd),
    .cmd_packet (cmd_packet),
    .seq_req    (seq_req),
    .seq_word   (seq_word),
    .seq_busy   (seq_busy),
    .full       (full),
    .seq_grant  (seq_grant),
    .wr         (wr),
    .wr_word    (wr_word)
  );

  stage_fifo i_stage_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .wr_word (wr_word),
    .rd      (rd),
    .rd_word (rd_word),
    .empty   (empty),
    .full    (full)
  );

  lane_repacker i_lane_repacker (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_word   (rd_word),
    .empty     (empty),
    .lanes     (lanes),
    .phy_full  (phy_full),
    .rd        (rd),
    .phy_data  (phy_data),
    .phy_write (phy_write)
  );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- tb_dsi_tx.sv
`timescale 1ns/100ps

module tb_dsi_tx;

  localparam int line_bytes = 8;
  localparam int blank_time = 6;
  localparam int vsa_lines  = 1;
  localparam int vbp_lines  = 1;
  localparam int act_lines  = 2;
  localparam int vfp_lines  = 1;
  localparam int n_rows     = 8;

  localparam logic [7:0] vss_id   = 8'h01;
  localparam logic [7:0] hss_id   = 8'h21;
  localparam logic [7:0] pixel_id = 8'h3E;

  typedef struct packed {
    logic [2:0]  lanes;
    logic        cmd_on;
    logic [23:0] cmd;
    logic        frame;
    logic        bp;
    logic        drop;  // line_ready low at the first pixel header
  } row_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] fifo_data = '0;
  logic        fifo_not_empty = 1'b0;
  logic        fifo_line_ready;
  logic        fifo_read_ack;
  logic        enable;
  logic        send_cmd;
  logic [23:0] cmd_packet;
  logic [2:0]  lanes;
  logic [32:0] phy_data;
  logic [3:0]  phy_write;
  logic [3:0]  phy_full = '0;
  logic        pix_underflow;

  row_t        rows [n_rows];
  string       row_name [n_rows];
  string       cur_name;
  int          cur_lanes;
  logic [8:0]  exp_q [$];  // {lp, byte}
  logic [8:0]  got_q [$];
  logic [31:0] pix_q [$];
  logic        ack_seen = 1'b0;
  logic        bp_on = 1'b0;
  int          ack_cnt;
  int          under_cnt;
  int          value_errors;
  int          hang_errors;

  tb_clk_gen #(.reset_cycles(16)) i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dsi_tx_assembler #(
    .line_bytes (line_bytes),
    .blank_time (blank_time),
    .vsa_lines  (vsa_lines),
    .vbp_lines  (vbp_lines),
    .act_lines  (act_lines),
    .vfp_lines  (vfp_lines)
  ) i_dsi_tx_assembler (
    .clk             (clk),
    .rst_n           (rst_n),
    .fifo_data       (fifo_data),
    .fifo_not_empty  (fifo_not_empty),
    .fifo_line_ready (fifo_line_ready),
    .fifo_read_ack   (fifo_read_ack),
    .enable          (enable),
    .send_cmd        (send_cmd),
    .cmd_packet      (cmd_packet),
    .lanes           (lanes),
    .phy_data        (phy_data),
    .phy_write       (phy_write),
    .phy_full        (phy_full),
    .pix_underflow   (pix_underflow)
  );

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual)
    begin
      value_errors++;
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // standard dsi hamming parity, one line per parity bit
  function automatic logic [7:0] ecc_of(input logic [23:0] d);
    logic [5:0] p;
    p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
    p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
    p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
    p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
    p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
    p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
    return {2'b00, p};
  endfunction

  // x^16+x^12+x^5+1, lsb first
  function automatic logic [15:0] crc_byte(input logic [15:0] crc_in, input logic [7:0] b);
    logic [15:0] c;
    logic        fb;
    c = crc_in;
    for (int i = 0; i < 8; i++)
    begin
      fb    = c[0] ^ b[i];
      c     = {fb, c[15:1]};
      c[10] = c[10] ^ fb;
      c[3]  = c[3] ^ fb;
    end
    return c;
  endfunction

  task automatic push_header(input logic [23:0] hdr, input logic lp);
    exp_q.push_back({lp, hdr[7:0]});
    exp_q.push_back({lp, hdr[15:8]});
    exp_q.push_back({lp, hdr[23:16]});
    exp_q.push_back({lp, ecc_of(hdr)});
  endtask

  task automatic build_frame();
    logic [15:0] crc;
    logic [31:0] w;
    push_header({16'h0000, vss_id}, 1'b0);
    for (int l = 0; l < vsa_lines + vbp_lines; l++)
      push_header({16'h0000, hss_id}, 1'b0);
    for (int l = 0; l < act_lines; l++)
    begin
      push_header({16'h0000, hss_id}, 1'b0);
      push_header({16'(line_bytes), pixel_id}, 1'b0);
      crc = 16'hFFFF;
      for (int k = 0; k < line_bytes / 4; k++)
      begin
        w = $urandom;
        pix_q.push_back(w);
        for (int b = 0; b < 4; b++)
        begin
          exp_q.push_back({1'b0, w[8*b +: 8]});
          crc = crc_byte(crc, w[8*b +: 8]);
        end
      end
      exp_q.push_back({1'b0, crc[7:0]});  // checksum low byte first
      exp_q.push_back({1'b0, crc[15:8]});
    end
    for (int l = 0; l < vfp_lines; l++)
      push_header({16'h0000, hss_id}, 1'b0);
  endtask

  task automatic collect();
    logic [3:0] next_mask;
    int         n;
    next_mask = phy_write + 4'd1;
    n         = $countones(phy_write);
    compare($sformatf("%s strobe from lane 0", cur_name), 0, phy_write & next_mask);
    compare($sformatf("%s strobe within lanes", cur_name), 1, n <= cur_lanes);
    if (phy_data[32])
      compare($sformatf("%s lp strobe count", cur_name), 1, n);
    for (int i = 0; i < n; i++)
      got_q.push_back({phy_data[32], phy_data[8*i +: 8]});
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (fifo_read_ack)
      begin
        ack_seen = 1'b1;
        ack_cnt++;
      end
      if (pix_underflow)
        under_cnt++;
      if (phy_write != 4'd0)
        collect();
    end
  end

  // pixel fifo model, pops one word per ack
  always @(posedge clk)
  begin
    #1;
    if (ack_seen && pix_q.size() > 0)
      void'(pix_q.pop_front());
    ack_seen       = 1'b0;
    fifo_not_empty = (pix_q.size() > 0);
    fifo_data      = fifo_not_empty ? pix_q[0] : 32'h0;
  end

  always @(posedge clk)
  begin
    #1;
    if (bp_on && ($urandom % 3) == 0)
      phy_full = 4'($urandom % 15 + 1);
    else
      phy_full = 4'd0;
  end

  task automatic next_cycle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_bytes(input int count, input int limit);
    int cyc;
    cyc = 0;
    while (got_q.size() < count && cyc < limit)
    begin
      next_cycle(1);
      cyc++;
    end
    if (got_q.size() < count)
    begin
      hang_errors++;
      $display("timeout in %s: got %0d of %0d bytes", cur_name, got_q.size(), count);
    end
  endtask

  task automatic wait_underflow(input int limit);
    int cyc;
    cyc = 0;
    while (under_cnt == 0 && cyc < limit)
    begin
      next_cycle(1);
      cyc++;
    end
    if (under_cnt == 0)
    begin
      hang_errors++;
      $display("timeout in %s: pix_underflow never pulsed", cur_name);
    end
  endtask

  task automatic set_row(input int i, input string name, input logic [2:0] ln,
                         input logic cmd_on, input logic [23:0] cmd,
                         input logic frame, input logic bp, input logic drop);
    row_t r;
    r.lanes     = ln;
    r.cmd_on    = cmd_on;
    r.cmd       = cmd;
    r.frame     = frame;
    r.bp        = bp;
    r.drop      = drop;
    rows[i]     = r;
    row_name[i] = name;
  endtask

  task automatic run_row(input int r);
    row_t row;
    row       = rows[r];
    cur_name  = row_name[r];
    cur_lanes = row.lanes;
    exp_q.delete();
    got_q.delete();
    ack_cnt    = 0;
    under_cnt  = 0;
    lanes      = row.lanes;
    cmd_packet = row.cmd;
    bp_on      = row.bp;
    if (row.frame)
      build_frame();
    if (row.cmd_on)
      push_header(row.cmd, 1'b1);  // command follows the whole frame
    next_cycle(2);
    if (row.frame)
    begin
      enable = 1'b1;
      next_cycle(1);
      enable = 1'b0;
      if (row.drop)
      begin
        next_cycle(2);
        fifo_line_ready = 1'b0;
        wait_underflow(400);
        if (hang_errors != 0)
          return;
        next_cycle(10);
        compare($sformatf("%s bytes before pixel header", cur_name), 16, got_q.size());
        compare($sformatf("%s acks during underflow", cur_name), 0, ack_cnt);
        fifo_line_ready = 1'b1;
      end
      if (row.cmd_on)
      begin
        wait_bytes(8, 400);  // mid frame
        if (hang_errors != 0)
          return;
      end
    end
    if (row.cmd_on)
    begin
      send_cmd = 1'b1;
      next_cycle(1);
      send_cmd = 1'b0;
    end
    wait_bytes(exp_q.size(), 4000);
    if (hang_errors != 0)
      return;
    bp_on = 1'b0;
    next_cycle(30);  // catches trailing extra bytes
    compare($sformatf("%s byte count", cur_name), exp_q.size(), got_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
      compare($sformatf("%s byte %0d", cur_name, i), exp_q[i], got_q[i]);
    if (row.frame)
      compare($sformatf("%s pixel read acks", cur_name),
              act_lines * line_bytes / 4, ack_cnt);
  endtask

  initial
  begin
    int cyc;
    void'($urandom(32'he9d7e1f6));
    fifo_line_ready = 1'b1;
    enable          = 1'b0;
    send_cmd        = 1'b0;
    cmd_packet      = '0;
    lanes           = 3'd4;
    value_errors    = 0;
    hang_errors     = 0;
    cur_name        = "reset";
    cur_lanes       = 4;
    set_row(0, "frame_lanes4", 3'd4, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b0);
    set_row(1, "frame_lanes1", 3'd1, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b0);
    set_row(2, "frame_lanes2", 3'd2, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b0);
    set_row(3, "frame_lanes3", 3'd3, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b0);
    set_row(4, "lp_command", 3'd4, 1'b1, 24'hA53905, 1'b0, 1'b0, 1'b0);
    set_row(5, "command_in_frame", 3'd2, 1'b1, 24'h5A1523, 1'b1, 1'b0, 1'b0);
    set_row(6, "back_pressure", 3'd4, 1'b0, 24'h000000, 1'b1, 1'b1, 1'b0);
    set_row(7, "line_underflow", 3'd3, 1'b0, 24'h000000, 1'b1, 1'b0, 1'b1);
    cyc = 0;
    while (!rst_n && cyc < 100)
    begin
      @(negedge clk);
      compare("reset phy_write", 0, phy_write);
      compare("reset fifo_read_ack", 0, fifo_read_ack);
      compare("reset pix_underflow", 0, pix_underflow);
      cyc++;
    end
    if (!rst_n)
    begin
      hang_errors++;
      $display("timeout: reset never released");
    end
    else
    begin
      next_cycle(1);
      for (int r = 0; r < n_rows; r++)
      begin
        run_row(r);
        if (hang_errors != 0)
          break;
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, hang_errors);
    if (value_errors == 0 && hang_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- dsi_tx_assembler.f
dsi_tx_pkg.sv
dsi_ecc.sv
dsi_crc16.sv
frame_sequencer.sv
packet_arbiter.sv
stage_fifo.sv
lane_repacker.sv
dsi_tx_assembler.sv
tb_clk_gen.sv
tb_dsi_tx.sv
